// ==== bench/cpu_bus_tb.sv ====
// CPU bus controller testbench
// runs CPU cycles from the test table against the DUT, answers SDRAM
// requests with a variable-latency model and checks read data,
// acknowledge timing and the number of memory requests per cycle

`timescale 1ns/1ps
`default_nettype none

module cpu_bus_tb;

    import cpu_bus_pkg::*;
    import mem_pkg::*;

    localparam int CEN_DIV    = 4;
    localparam int CNT_W      = 4;
    localparam int RST_CYCLES = 4;

    logic              clk, rst;
    logic              as_n, rw, dtack_n;
    logic [CPU_AW-1:0] addr;
    logic [MEM_DW-1:0] wdata, rdata, mem_data;
    logic              mem_req, mem_ok;
    logic [MEM_AW-1:0] mem_addr;

    // test table with one entry per CPU cycle
    logic              t_write [$];
    logic [CPU_AW-1:0] t_addr [$];
    logic [MEM_DW-1:0] t_wdata [$];
    int                t_lat [$];
    logic              t_rand [$];     // SDRAM word comes from $random
    logic [MEM_DW-1:0] t_word [$];

    int                seed = 36464;
    int                limit = 0;      // clk budget known once the table is read
    int                cycles = 0;
    int                req_count;      // requests seen in the running cycle
    int                cur_lat;        // what the SDRAM model answers with
    logic [MEM_DW-1:0] cur_word;
    logic [MEM_AW-1:0] cur_maddr;

    cpu_bus_top #(.CEN_DIV(CEN_DIV), .CNT_W(CNT_W)) u_dut (
        .clk(clk), .rst(rst), .as_n(as_n), .addr(addr), .rw(rw), .wdata(wdata),
        .dtack_n(dtack_n), .rdata(rdata), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_ok(mem_ok), .mem_data(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [MEM_DW-1:0] got, exp);
        if (got !== exp) stop_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [MEM_AW-1:0] got, exp);
        if (got !== exp) stop_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, exp);
        if (got !== exp) stop_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    // memory map as the board defines it
    function automatic region_t region_of(input logic [CPU_AW-1:0] a);
        if (a <= ROM_TOP) return REGION_ROM;
        if (a >= IO_BASE && a < IO_BASE + 16) return REGION_IO;    // 16-word block
        return REGION_NONE;
    endfunction

    task automatic load_tests();
        int                fd;
        int                n;
        int                lat;
        int                max_lat;
        string             line, op_s, exp_s;
        logic [CPU_AW-1:0] a;
        logic [MEM_DW-1:0] w;
        max_lat = 0;
        fd = $fopen("bench/cpu_bus_tests.txt", "r");
        if (fd == 0) stop_run("cannot open bench/cpu_bus_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or column notes
            n = $sscanf(line, "%s %h %h %d %s", op_s, a, w, lat, exp_s);
            if (n != 5) stop_run({"malformed line in test file: ", line});
            t_write.push_back(op_s == "W");
            t_addr.push_back(a);
            t_wdata.push_back(w);
            t_lat.push_back(lat);
            t_rand.push_back(exp_s == "R");
            t_word.push_back(MEM_DW'(exp_s.atohex()));
            if (lat > max_lat) max_lat = lat;
        end
        $fclose(fd);
        limit = RST_CYCLES + 4 + t_addr.size() * (4 * CEN_DIV + max_lat + 8);
    endtask

    initial begin : watchdog
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        stop_run($sformatf("timeout, no end of test after %0d clk cycles", cycles));
    end

    // SDRAM model answers each request after the latency of the running cycle
    initial begin : sdram_model
        forever begin
            @(posedge clk);
            if (!rst && mem_req) begin
                req_count++;
                check_addr("mem_addr", mem_addr, cur_maddr);
                repeat (cur_lat) begin
                    @(posedge clk);
                    check_level("mem_req", mem_req, 1'b1);  // no dropped request
                    check_level("dtack_n", dtack_n, 1'b1);  // no ack during the stall
                end
                mem_data <= cur_word;
                mem_ok   <= 1'b1;
                @(posedge clk);
                mem_ok   <= 1'b0;
                check_level("dtack_n", dtack_n, 1'b1);
            end
        end
    end

    initial begin : main
        region_t           kind;
        int                waited;     // clk from as_n fall to dtack_n seen low
        logic [MEM_DW-1:0] expect_rd;
        as_n = 1'b1;
        rw = 1'b1;
        addr = '0;
        wdata = '0;
        mem_ok = 1'b0;
        mem_data = '0;
        rst = 1'b1;
        load_tests();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_level("dtack_n", dtack_n, 1'b1);
        check_level("mem_req", mem_req, 1'b0);
        for (int i = 0; i < t_addr.size(); i++) begin
            kind = region_of(t_addr[i]);
            expect_rd = t_rand[i] ? MEM_DW'($random(seed)) : t_word[i];
            cur_lat   = t_lat[i];
            cur_word  = expect_rd;               // ROM reads return the model word
            cur_maddr = t_addr[i][MEM_AW-1:0];
            req_count = 0;
            addr  <= t_addr[i];
            rw    <= !t_write[i];
            wdata <= t_wdata[i];
            as_n  <= 1'b0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (dtack_n);
            if (!t_write[i]) check_word("rdata", rdata, expect_rd);
            if (kind != REGION_ROM) begin
                if (waited < 2 * CEN_DIV || waited > 4 * CEN_DIV + 1)
                    stop_run($sformatf("cycle %0d acknowledged after %0d clk, out of range",
                                       i, waited));
            end else if (t_lat[i] == 0 && waited > 4 * CEN_DIV + 1) begin
                stop_run($sformatf("fast ROM cycle %0d took %0d clk", i, waited));
            end
            as_n <= 1'b1;
            @(posedge clk);                      // strobe not yet seen high
            @(posedge clk);
            check_level("dtack_n", dtack_n, 1'b1);
            if (req_count != ((kind == REGION_ROM) ? 1 : 0))
                stop_run($sformatf("cycle %0d issued %0d SDRAM requests", i, req_count));
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cpu_bus_tests.txt ====
# op addr wdata latency expected: op W write or R read, addr word address in hex,
# wdata hex, latency SDRAM clk, expected rdata hex or R for a random SDRAM word
W 400000 1234 0 0000
W 400001 abcd 0 0000
W 400003 5a5a 0 0000
W 400001 beef 0 0000
W 400007 8001 0 0000
W 700000 ffff 0 0000
R 400000 0000 0 1234
R 400001 0000 0 beef
R 400002 0000 0 0000
R 400003 0000 0 5a5a
R 400005 0000 0 0000
R 400007 0000 0 8001
R 600000 0000 0 0000
R 200000 0000 0 0000
R 000100 0000 3 1a2b
R 0fffff 0000 1 R
R 012345 0000 7 R
R 000000 0000 12 c0de
R 055555 0000 12 R
R 0abcde 0000 10 R
R 000010 0000 0 4d2e
R 000012 0000 0 R
R 000014 0000 0 7777
R 400003 0000 0 5a5a

// ==== cpu_bus.f ====
verilog/cpu_bus_pkg.sv
verilog/mem_pkg.sv
verilog/cpu_cen.sv
verilog/bus_decoder.sv
verilog/dtack_gen.sv
verilog/mem_port.sv
verilog/io_regs.sv
verilog/cpu_bus_top.sv
bench/cpu_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the CPU bus controller testbench with Verilator and run it
# a failing check ends the simulation with $fatal, so the exit status is nonzero
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module cpu_bus_tb \
    -f cpu_bus.f

./obj_dir/Vcpu_bus_tb

// ==== verilog/bus_decoder.sv ====
// address decoder
// sorts the current CPU cycle into program ROM, local I/O or open bus
// and flags the slow I/O region for one extra wait state

`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire logic                         as_n,
    input  wire logic [cpu_bus_pkg::CPU_AW-1:0] addr,
    output cpu_bus_pkg::region_t              region,
    output logic                              rom_cs,
    output logic                              io_cs,
    output logic                              one_wait
);

    import cpu_bus_pkg::*;

    logic in_rom;   // address inside the ROM window
    logic in_io;    // address inside the I/O block

    assign in_rom = (addr <= ROM_TOP);
    assign in_io  = (addr[CPU_AW-1:IO_AW] == IO_BASE[CPU_AW-1:IO_AW]);

    always_comb begin
        region = REGION_NONE;       // nothing selected outside a cycle
        if (!as_n) begin
            if (in_rom) begin
                region = REGION_ROM;
            end else if (in_io) begin
                region = REGION_IO;
            end
        end
    end

    // selects only live while the address strobe is low
    assign rom_cs = (region == REGION_ROM);
    assign io_cs  = (region == REGION_IO);

    // peripheral chips on the I/O block need the extra wait
    assign one_wait = io_cs;

endmodule

`default_nettype wire

// ==== verilog/cpu_bus_pkg.sv ====
// cpu bus package
// CPU-side address width, memory map boundaries, the bus target
// encoding and the phases of the acknowledge generator

`default_nettype none

package cpu_bus_pkg;

    // 68000 word address: A23..A1, byte lanes handled by the CPU
    localparam int CPU_AW = 23;

    // program ROM covers word 0 up to and including ROM_TOP (2 MB)
    localparam logic [CPU_AW-1:0] ROM_TOP = 23'h0F_FFFF;

    // local I/O sits at byte address 0x800000
    localparam logic [CPU_AW-1:0] IO_BASE = 23'h40_0000;

    // log2 of the I/O block size in words, 16 words decoded
    localparam int IO_AW = 4;

    // which target a bus cycle goes to
    typedef enum logic [1:0] {
        REGION_ROM  = 2'd0,    // SDRAM-backed program ROM
        REGION_IO   = 2'd1,    // local register block
        REGION_NONE = 2'd2     // open bus, reads back zero
    } region_t;

    // acknowledge generator phase within one CPU cycle
    //   PH_IDLE  as_n high, no cycle running
    //   PH_WAIT  strobe seen, counting wait states / waiting for SDRAM
    //   PH_ACK   dtack_n asserted, waiting for as_n to rise
    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_WAIT = 2'd1,
        PH_ACK  = 2'd2
    } wait_phase_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_bus_top.sv ====
// CPU bus controller top level
// clock enables, address decode, DTACK generation, SDRAM port for the
// program ROM, local I/O registers and the read data mux

`timescale 1ns/1ps
`default_nettype none

module cpu_bus_top #(
    parameter int CEN_DIV = 4,
    parameter int CNT_W   = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    // CPU side
    input  wire logic                           as_n,
    input  wire logic [cpu_bus_pkg::CPU_AW-1:0] addr,
    input  wire logic                           rw,
    input  wire logic [mem_pkg::MEM_DW-1:0]     wdata,
    output logic                                dtack_n,
    output logic [mem_pkg::MEM_DW-1:0]          rdata,
    // SDRAM side
    output logic                                mem_req,
    output logic [mem_pkg::MEM_AW-1:0]          mem_addr,
    input  wire logic                           mem_ok,
    input  wire logic [mem_pkg::MEM_DW-1:0]     mem_data
);

    import cpu_bus_pkg::*;
    import mem_pkg::*;

    logic        cen_cpu, cen_cpu_b;
    region_t     region;
    logic        rom_cs, io_cs, one_wait;
    logic        bus_busy, rom_ok;
    logic [MEM_DW-1:0] rom_data, io_data;

    cpu_cen #(.CEN_DIV(CEN_DIV)) u_cen (
        .clk(clk), .rst(rst), .cen_cpu(cen_cpu), .cen_cpu_b(cen_cpu_b)
    );

    bus_decoder u_dec (
        .as_n(as_n), .addr(addr), .region(region),
        .rom_cs(rom_cs), .io_cs(io_cs), .one_wait(one_wait)
    );

    dtack_gen #(.CNT_W(CNT_W)) u_dtack (
        .clk(clk), .rst(rst), .cen_cpu(cen_cpu), .cen_cpu_b(cen_cpu_b),
        .as_n(as_n), .one_wait(one_wait), .rom_cs(rom_cs),
        .bus_busy(bus_busy), .rom_ok(rom_ok), .dtack_n(dtack_n)
    );

    mem_port u_mem (
        .clk(clk), .rst(rst), .as_n(as_n), .rom_cs(rom_cs),
        .addr(addr[MEM_AW-1:0]), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_ok(mem_ok), .mem_data(mem_data), .rom_data(rom_data),
        .bus_busy(bus_busy), .rom_ok(rom_ok)
    );

    io_regs u_io (
        .clk(clk), .rst(rst), .io_cs(io_cs), .rw(rw), .dtack_n(dtack_n),
        .reg_sel(addr[2:0]), .wdata(wdata), .io_data(io_data)
    );

    always_comb begin
        case (region)
            REGION_ROM: rdata = rom_data;
            REGION_IO:  rdata = io_data;
            default:    rdata = '0;     // open bus reads zero
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_cen.sv ====
// CPU clock enable generator
// divides clk by CEN_DIV into two one-clk strobes half a CPU period
// apart: cen_cpu marks the rising CPU clock edge, cen_cpu_b the falling

`timescale 1ns/1ps
`default_nettype none

module cpu_cen #(
    parameter int CEN_DIV = 4       // clk cycles per CPU clock
) (
    input  wire logic clk,
    input  wire logic rst,
    output logic      cen_cpu,
    output logic      cen_cpu_b
);

    localparam int CW = (CEN_DIV > 2) ? $clog2(CEN_DIV) : 1;

    logic [CW-1:0] cnt;

    // free running modulo counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CW'(CEN_DIV - 1)) begin
            cnt <= '0;                      // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign cen_cpu   = (cnt == '0);
    assign cen_cpu_b = (cnt == CW'(CEN_DIV / 2));   // half period later

    // both strobes in one clk would break the wait-state count
    a_cen_apart: assert property (@(posedge clk) disable iff (rst)
        !(cen_cpu && cen_cpu_b))
        else $error("cen_cpu and cen_cpu_b overlap");

endmodule

`default_nettype wire

// ==== verilog/dtack_gen.sv ====
// DTACK generator
// holds the acknowledge back for the standard bus wait states, one more
// on slow regions, and for as long as the SDRAM port is busy on ROM
// cycles. CPU clocks lost to SDRAM stalls are counted and won back by
// acknowledging later ROM cycles one wait state early.

`timescale 1ns/1ps
`default_nettype none

module dtack_gen #(
    parameter int CNT_W = 4         // stall compensation counter width
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cen_cpu,
    input  wire logic cen_cpu_b,
    input  wire logic as_n,
    input  wire logic one_wait,
    input  wire logic rom_cs,
    input  wire logic bus_busy,
    input  wire logic rom_ok,       // SDRAM has answered at least once
    output logic      dtack_n
);

    import cpu_bus_pkg::*;

    wait_phase_t      phase;
    logic             as_n_l;       // as_n one clk back, for the edge
    logic             armed;        // cycle aligned to a CPU clock edge
    logic [2:0]       wait_sh;      // wait states, fills with ones
    logic [CNT_W-1:0] cnt;          // CPU clocks owed to the program
    logic             as_fall;
    logic             done;         // standard wait has passed
    logic             early;        // one wait short, allowed if owed
    logic             can_ack;
    logic             early_ack;

    assign as_fall   = !as_n && as_n_l;
    assign done      = wait_sh[2];
    assign early     = wait_sh[1] && (cnt != '0) && rom_ok;
    // ROM cycles also need the memory port to be free
    assign can_ack   = rom_cs ? (!bus_busy && (done || early)) : done;
    assign early_ack = rom_cs && !bus_busy && !done && early;

    assign dtack_n = (phase != PH_ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= PH_IDLE;
            as_n_l  <= 1'b1;
            armed   <= 1'b0;
            wait_sh <= '0;
            cnt     <= '0;
        end else begin
            as_n_l <= as_n;
            if (as_n) begin
                phase <= PH_IDLE;               // releases dtack_n
                armed <= 1'b0;
            end else if (as_fall) begin
                phase   <= PH_WAIT;
                armed   <= 1'b0;
                wait_sh <= {2'b00, ~one_wait};  // slow region starts one back
            end else if (phase == PH_WAIT) begin
                if (cen_cpu) armed <= 1'b1;
                if (cen_cpu_b && armed) wait_sh <= {wait_sh[1:0], 1'b1};
                // wait is over but SDRAM still busy, one clock lost
                if (rom_cs && done && bus_busy && rom_ok && cen_cpu && (cnt != '1)) begin
                    cnt <= cnt + 1'b1;
                end
                if (can_ack) begin
                    phase <= PH_ACK;
                    if (early_ack) cnt <= cnt - 1'b1;   // one clock recovered
                end
            end
        end
    end

    // acknowledge released one clk after the strobe goes away
    a_ack_idle: assert property (@(posedge clk) disable iff (rst)
        $past(as_n) |-> dtack_n)
        else $error("dtack_n low with as_n high");

    // no ROM acknowledge while the memory port still holds the request
    a_ack_busy: assert property (@(posedge clk) disable iff (rst)
        ($fell(dtack_n) && $past(rom_cs)) |-> !$past(bus_busy))
        else $error("ROM cycle acknowledged while SDRAM busy");

    a_cnt_step: assert property (@(posedge clk) disable iff (rst)
        (cnt == $past(cnt))
        || ((cnt > $past(cnt)) && (cnt - $past(cnt) == 1))
        || ((cnt < $past(cnt)) && ($past(cnt) - cnt == 1)))
        else $error("stall count wrapped");

endmodule

`default_nettype wire

// ==== verilog/io_regs.sv ====
// local I/O register block
// eight 16-bit registers written by the CPU, read back combinationally

`timescale 1ns/1ps
`default_nettype none

module io_regs (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        io_cs,
    input  wire logic                        rw,        // high for read
    input  wire logic                        dtack_n,
    input  wire logic [2:0]                  reg_sel,
    input  wire logic [mem_pkg::MEM_DW-1:0]  wdata,
    output logic [mem_pkg::MEM_DW-1:0]       io_data
);

    import mem_pkg::*;

    logic [MEM_DW-1:0] regs [8];
    logic              dtack_l;     // dtack_n one clk back
    logic              wr_en;

    // one write per cycle, on the clk the acknowledge goes low
    assign wr_en = io_cs && !rw && !dtack_n && dtack_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_l <= 1'b1;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            dtack_l <= dtack_n;
            if (wr_en) regs[reg_sel] <= wdata;
        end
    end

    assign io_data = regs[reg_sel];     // block mirrors every 8 words

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
// memory port package
// widths of the shared SDRAM port and the request state encoding

`default_nettype none

package mem_pkg;

    // SDRAM word address, 1M words of program ROM
    localparam int MEM_AW = 20;

    // 16-bit data bus, same as the CPU
    localparam int MEM_DW = 16;

    // request tracking for one CPU ROM cycle
    typedef enum logic [1:0] {
        MP_IDLE = 2'd0,    // no ROM cycle, ready to latch a new one
        MP_REQ  = 2'd1,    // mem_req up, waiting on mem_ok
        MP_DONE = 2'd2     // word captured, hold until as_n rises
    } port_state_t;

endpackage

`default_nettype wire

// ==== verilog/mem_port.sv ====
// SDRAM memory port
// turns a CPU ROM cycle into one request on the shared SDRAM port,
// flags busy to the DTACK logic and captures the returned word

`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        as_n,
    input  wire logic                        rom_cs,
    input  wire logic [mem_pkg::MEM_AW-1:0]  addr,
    output logic                             mem_req,
    output logic [mem_pkg::MEM_AW-1:0]       mem_addr,
    input  wire logic                        mem_ok,
    input  wire logic [mem_pkg::MEM_DW-1:0]  mem_data,
    output logic [mem_pkg::MEM_DW-1:0]       rom_data,
    output logic                             bus_busy,
    output logic                             rom_ok
);

    import mem_pkg::*;

    port_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= MP_IDLE;
            rom_ok <= 1'b0;
        end else begin
            if (mem_ok) rom_ok <= 1'b1;         // sticky once SDRAM is up
            case (state)
                MP_IDLE: begin
                    if (!as_n && rom_cs) state <= MP_REQ;
                end
                MP_REQ: begin
                    if (mem_ok) state <= MP_DONE;
                end
                MP_DONE: begin
                    if (as_n) state <= MP_IDLE; // one request per cycle
                end
                default: state <= MP_IDLE;
            endcase
        end
    end

    // address and data words
    always_ff @(posedge clk) begin
        if (state == MP_IDLE && !as_n && rom_cs) begin
            mem_addr <= addr;                   // held for the whole request
        end
        if (state == MP_REQ && mem_ok) begin
            rom_data <= mem_data;
        end
    end

    assign mem_req  = (state == MP_REQ);
    assign bus_busy = (state == MP_REQ);        // drops the clk after mem_ok

    // the SDRAM side must only answer an open request
    a_ok_req: assert property (@(posedge clk) disable iff (rst)
        mem_ok |-> mem_req)
        else $error("mem_ok without mem_req");

endmodule

`default_nettype wire
